/* design/hdc_pkg.sv */
`default_nettype none

package hdc_pkg;

    // hypervector split into equal slices, one per core
    localparam int num_cores = 8;

    // bits per slice, also the item word width
    localparam int slice_width = 32;

    // full hypervector
    localparam int hv_width = num_cores * slice_width;

    // item memory entries per core
    localparam int item_depth = 100;

    // symbol / item address width, covers item_depth
    localparam int sym_width = 7;

    // core select on item writes
    localparam int core_idx_width = 3;

    // rotation amount, position wraps mod 32
    localparam int pos_width = 5;

    // accepted symbol to accumulator update
    // addr reg, ram out reg, relief reg
    localparam int pipe_latency = 3;

endpackage

`default_nettype wire

/* design/hdc_core.sv */
`default_nettype none

module hdc_core (
    input wire clk,
    input wire reset,
    input wire mem_wr,
    input wire [hdc_pkg::sym_width-1:0] mem_addr,
    input wire [hdc_pkg::slice_width-1:0] mem_data,
    input wire exec,
    input wire [hdc_pkg::sym_width-1:0] sym,
    input wire clear,
    input wire capture,
    input wire shift,
    input wire [hdc_pkg::slice_width-1:0] chain_in,
    output logic [hdc_pkg::slice_width-1:0] out_word
);

    // item memory, one random word per symbol
    logic [hdc_pkg::slice_width-1:0] item_mem [hdc_pkg::item_depth];

    // read pipeline data
    logic [hdc_pkg::sym_width-1:0] rd_addr;
    logic [hdc_pkg::slice_width-1:0] rd_word;
    logic [hdc_pkg::slice_width-1:0] relief_word;

    // control delay, index 0 is one cycle after the strobe
    logic [hdc_pkg::pipe_latency-1:0] exec_dly;
    logic [hdc_pkg::pipe_latency-1:0] clear_dly;

    // running slice state
    logic [hdc_pkg::slice_width-1:0] acc;
    logic [hdc_pkg::pos_width-1:0] pos;
    logic [hdc_pkg::slice_width-1:0] rotated;

    // host load port
    always_ff @(posedge clk) begin
        if (mem_wr) begin
            item_mem[mem_addr] <= mem_data;
        end
    end

    // stage 1 latches the address, stage 2 reads the ram,
    // stage 3 is only there to break the path into the rotator
    always_ff @(posedge clk) begin
        if (exec) begin
            rd_addr <= sym;
        end
        if (exec_dly[0]) begin
            rd_word <= item_mem[rd_addr];
        end
        if (exec_dly[1]) begin
            relief_word <= rd_word;
        end
    end

    // clear rides the same delay as exec
    // so it lands in order with the symbols around it
    always_ff @(posedge clk) begin
        if (reset) begin
            exec_dly <= '0;
            clear_dly <= '0;
        end else begin
            exec_dly <= {exec_dly[hdc_pkg::pipe_latency-2:0], exec};
            clear_dly <= {clear_dly[hdc_pkg::pipe_latency-2:0], clear};
        end
    end

    // rotate right by position
    always_comb begin
        logic [2*hdc_pkg::slice_width-1:0] doubled;
        doubled = {relief_word, relief_word} >> pos;
        rotated = doubled[hdc_pkg::slice_width-1:0];
    end

    // accumulate, position wraps on its own at 32
    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
            pos <= '0;
        end else if (clear_dly[hdc_pkg::pipe_latency-1]) begin
            acc <= '0;
            pos <= '0;
        end else if (exec_dly[hdc_pkg::pipe_latency-1]) begin
            acc <= acc ^ rotated;
            pos <= pos + 1'b1;
        end
    end

    // chain register
    // capture snapshots the slice, shift pulls from the next core
    always_ff @(posedge clk) begin
        if (capture) begin
            out_word <= acc;
        end else if (shift) begin
            out_word <= chain_in;
        end
    end

endmodule

`default_nettype wire

/* design/hdc_core_array.sv */
`default_nettype none

module hdc_core_array (
    input wire clk,
    input wire reset,
    input wire mem_wr,
    input wire [hdc_pkg::core_idx_width-1:0] mem_core,
    input wire [hdc_pkg::sym_width-1:0] mem_addr,
    input wire [hdc_pkg::slice_width-1:0] mem_data,
    input wire exec,
    input wire [hdc_pkg::sym_width-1:0] sym,
    input wire clear,
    input wire capture,
    input wire shift,
    output logic [hdc_pkg::slice_width-1:0] out_word
);

    // one write enable per core
    logic [hdc_pkg::num_cores-1:0] wr_en;

    // chain register of every core
    logic [hdc_pkg::slice_width-1:0] core_out [hdc_pkg::num_cores];

    // write decode by core index
    always_comb begin
        wr_en = '0;
        if (mem_wr) begin
            wr_en[mem_core] = 1'b1;
        end
    end

    for (genvar i = 0; i < hdc_pkg::num_cores; i++) begin : g_core
        logic [hdc_pkg::slice_width-1:0] chain_in;

        // last core feeds zeros into the chain
        if (i == hdc_pkg::num_cores - 1) begin : g_tail
            assign chain_in = '0;
        end else begin : g_link
            assign chain_in = core_out[i+1];
        end

        // symbol, exec and clear are broadcast to all slices
        hdc_core u_hdc_core (
            .clk      (clk),
            .reset    (reset),
            .mem_wr   (wr_en[i]),
            .mem_addr (mem_addr),
            .mem_data (mem_data),
            .exec     (exec),
            .sym      (sym),
            .clear    (clear),
            .capture  (capture),
            .shift    (shift),
            .chain_in (chain_in),
            .out_word (core_out[i])
        );
    end

    // slices leave through core 0
    assign out_word = core_out[0];

endmodule

`default_nettype wire

/* design/hdc_sequencer.sv */
`default_nettype none

module hdc_sequencer (
    input wire clk,
    input wire reset,
    input wire init,
    input wire sym_valid,
    input wire finish,
    output logic exec,
    output logic clear,
    output logic capture,
    output logic shift,
    output logic out_valid,
    output logic busy
);

    typedef enum logic [1:0] {
        st_idle,
        st_drain,
        st_output
    } state_t;

    // counts drain cycles up to pipe_latency
    typedef logic [$clog2(hdc_pkg::pipe_latency + 1)-1:0] drain_cnt_t;

    // one count per output slice
    typedef logic [hdc_pkg::core_idx_width-1:0] word_cnt_t;

    state_t state;
    drain_cnt_t drain_cnt;
    word_cnt_t word_cnt;

    logic drain_done;
    logic last_word;

    // anything but idle blocks the host strobes
    assign busy = (state != st_idle);

    // strobes pass straight through while idle
    assign exec = sym_valid && !busy;
    assign clear = init && !busy;

    // last symbol has reached the accumulators
    assign drain_done = (state == st_drain) &&
                        (drain_cnt == drain_cnt_t'(hdc_pkg::pipe_latency));

    assign last_word = (word_cnt == word_cnt_t'(hdc_pkg::num_cores - 1));

    // snapshot on the final drain cycle
    assign capture = drain_done;

    // one beat per slice, core 0 first
    assign out_valid = (state == st_output);

    // no shift after the eighth beat
    assign shift = out_valid && !last_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            drain_cnt <= '0;
            word_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    // finish accepted only here
                    if (finish) begin
                        state <= st_drain;
                        drain_cnt <= '0;
                    end
                end
                st_drain: begin
                    if (drain_done) begin
                        state <= st_output;
                        word_cnt <= '0;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                st_output: begin
                    if (last_word) begin
                        state <= st_idle;
                    end else begin
                        word_cnt <= word_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/hdc_encoder_top.sv */
`default_nettype none

module hdc_encoder_top (
    input wire clk,
    input wire reset,
    input wire mem_wr,
    input wire [hdc_pkg::core_idx_width-1:0] mem_core,
    input wire [hdc_pkg::sym_width-1:0] mem_addr,
    input wire [hdc_pkg::slice_width-1:0] mem_data,
    input wire init,
    input wire sym_valid,
    input wire [hdc_pkg::sym_width-1:0] sym,
    input wire finish,
    output logic out_valid,
    output logic [hdc_pkg::slice_width-1:0] out_data,
    output logic busy
);

    // sequencer to core array controls
    logic exec;
    logic clear;
    logic capture;
    logic shift;

    // strobe gating and output framing
    hdc_sequencer u_hdc_sequencer (
        .clk       (clk),
        .reset     (reset),
        .init      (init),
        .sym_valid (sym_valid),
        .finish    (finish),
        .exec      (exec),
        .clear     (clear),
        .capture   (capture),
        .shift     (shift),
        .out_valid (out_valid),
        .busy      (busy)
    );

    // sym goes straight to the cores
    // only exec decides whether it is used
    hdc_core_array u_hdc_core_array (
        .clk      (clk),
        .reset    (reset),
        .mem_wr   (mem_wr),
        .mem_core (mem_core),
        .mem_addr (mem_addr),
        .mem_data (mem_data),
        .exec     (exec),
        .sym      (sym),
        .clear    (clear),
        .capture  (capture),
        .shift    (shift),
        .out_word (out_data)
    );

endmodule

`default_nettype wire

/* sim/hdc_tb_model.svh */
`ifndef HDC_TB_MODEL_SVH
`define HDC_TB_MODEL_SVH

// host copy of every item word indexed [core][symbol]
logic [hdc_pkg::slice_width-1:0] model_item [hdc_pkg::num_cores][hdc_pkg::item_depth];

// symbols of the open sequence in arrival order
int unsigned model_syms[$];

// mirror one item write
function automatic void model_write(input int core, input int addr,
                                    input logic [hdc_pkg::slice_width-1:0] data);
    model_item[core][addr] = data;
endfunction

// init starts from an empty sequence
function automatic void model_clear();
    model_syms.delete();
endfunction

function automatic void model_push(input int unsigned s);
    model_syms.push_back(s);
endfunction

// rotate right by amt in 0..31
function automatic logic [hdc_pkg::slice_width-1:0] rotate_right(
    input logic [hdc_pkg::slice_width-1:0] w,
    input int amt
);
    return (w >> amt) | (w << (hdc_pkg::slice_width - amt));
endfunction

// expected slice of one core
// xor over p of item[sym_p] rotated right by p mod 32
// output word k carries the slice of core k
function automatic logic [hdc_pkg::slice_width-1:0] model_slice(input int core);
    logic [hdc_pkg::slice_width-1:0] acc;
    acc = '0;
    foreach (model_syms[p]) begin
        acc ^= rotate_right(model_item[core][model_syms[p]], p % hdc_pkg::slice_width);
    end
    return acc;
endfunction

`endif

/* sim/hdc_tb.sv */
`default_nettype none

module hdc_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 8;
    localparam int reset_cycles = 4;
    localparam int n_loads = hdc_pkg::num_cores * hdc_pkg::item_depth;
    localparam int n_item_checks = 6;
    localparam int n_rand_seq = 24;
    localparam int n_restart = 4;
    localparam int n_busy = 4;
    localparam int n_gap_seq = 6;
    localparam int max_syms = 70;
    localparam int max_gap = 3;
    // drain, eight beats, junk window and idle tail
    localparam int seq_overhead = 2 * (hdc_pkg::pipe_latency + hdc_pkg::num_cores) + 8;
    localparam int beat_timeout = hdc_pkg::pipe_latency + hdc_pkg::num_cores + 8;
    // one entry per finish
    localparam int n_finish = n_item_checks + n_rand_seq + n_restart + 2 * n_busy
                              + 2 * n_gap_seq;
    localparam int watchdog_cycles = 2 * (reset_cycles + n_loads
                                     + n_finish * (max_syms * (max_gap + 1) + seq_overhead));

    logic clk;
    logic reset;
    logic mem_wr;
    logic [hdc_pkg::core_idx_width-1:0] mem_core;
    logic [hdc_pkg::sym_width-1:0] mem_addr;
    logic [hdc_pkg::slice_width-1:0] mem_data;
    logic init;
    logic sym_valid;
    logic [hdc_pkg::sym_width-1:0] sym;
    logic finish;
    logic out_valid;
    logic [hdc_pkg::slice_width-1:0] out_data;
    logic busy;

    int errors;
    int checks;
    int cyc;
    int fin_cyc;
    // beats of the current finish
    logic [hdc_pkg::slice_width-1:0] got[$];
    // symbol list of the next sequence
    int unsigned stim[$];

    `include "hdc_tb_model.svh"

    hdc_encoder_top u_hdc_encoder_top (
        .clk       (clk),
        .reset     (reset),
        .mem_wr    (mem_wr),
        .mem_core  (mem_core),
        .mem_addr  (mem_addr),
        .mem_data  (mem_data),
        .init      (init),
        .sym_valid (sym_valid),
        .sym       (sym),
        .finish    (finish),
        .out_valid (out_valid),
        .out_data  (out_data),
        .busy      (busy)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // rising edges so far
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL t=%0t %s: expected %h, got %h", $time, what, expected, actual);
        end
    endtask

    // beats collected on the falling edge
    // first beat pipe_latency+2 cycles after finish, then one per cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (finish && !busy) begin
                fin_cyc = cyc;
            end
            if (out_valid) begin
                check_value(fin_cyc + hdc_pkg::pipe_latency + 2 + got.size(), cyc,
                            "beat timing");
                check_value(1, 32'(busy), "busy during beat");
                got.push_back(out_data);
            end
        end
    end

    // wait for the next drive point 1 ns past the rising edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic load_item(input int core, input int addr,
                             input logic [hdc_pkg::slice_width-1:0] data);
        mem_wr = 1'b1;
        mem_core = core[hdc_pkg::core_idx_width-1:0];
        mem_addr = addr[hdc_pkg::sym_width-1:0];
        mem_data = data;
        model_write(core, addr, data);
        tick();
        mem_wr = 1'b0;
    endtask

    task automatic do_init();
        init = 1'b1;
        model_clear();
        tick();
        init = 1'b0;
    endtask

    task automatic do_sym(input int unsigned s);
        sym_valid = 1'b1;
        sym = s[hdc_pkg::sym_width-1:0];
        model_push(s);
        tick();
        sym_valid = 1'b0;
    endtask

    task automatic fill_stim(input int n);
        stim.delete();
        repeat (n) stim.push_back($urandom_range(hdc_pkg::item_depth - 1, 0));
    endtask

    // up to gap_max random idle cycles after each symbol
    task automatic send_stim(input int gap_max);
        foreach (stim[i]) begin
            do_sym(stim[i]);
            repeat ($urandom_range(gap_max, 0)) tick();
        end
    endtask

    // init or a symbol on every busy cycle
    // never both in one cycle
    task automatic drive_junk(input int cycles);
        int unsigned r;
        repeat (cycles) begin
            r = $urandom();
            init = r[0];
            sym_valid = !r[0];
            r = $urandom_range(hdc_pkg::item_depth - 1, 0);
            sym = r[hdc_pkg::sym_width-1:0];
            tick();
        end
        init = 1'b0;
        sym_valid = 1'b0;
    endtask

    task automatic do_finish(input bit junk, input string tag);
        int waited;
        got.delete();
        finish = 1'b1;
        tick();
        finish = 1'b0;
        check_value(1, 32'(busy), {tag, " busy after finish"});
        if (junk) begin
            drive_junk(hdc_pkg::pipe_latency + hdc_pkg::num_cores);
        end
        waited = 0;
        while (got.size() < hdc_pkg::num_cores && waited < beat_timeout) begin
            tick();
            waited++;
        end
        if (got.size() < hdc_pkg::num_cores) begin
            errors++;
            $display("ERROR t=%0t %s: only %0d output beats arrived after finish",
                     $time, tag, got.size());
        end
        // no ninth beat and busy back low
        repeat (2) tick();
        check_value(hdc_pkg::num_cores, got.size(), {tag, " beat count"});
        check_value(0, 32'(busy), {tag, " busy after output"});
        for (int k = 0; k < got.size(); k++) begin
            check_value(model_slice(k), got[k], $sformatf("%s slice %0d", tag, k));
        end
    endtask

    initial begin
        int n;
        int s;
        void'($urandom(63));
        reset = 1'b1;
        mem_wr = 1'b0;
        mem_core = '0;
        mem_addr = '0;
        mem_data = '0;
        init = 1'b0;
        sym_valid = 1'b0;
        sym = '0;
        finish = 1'b0;
        errors = 0;
        checks = 0;
        cyc = 0;
        fin_cyc = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b0;

        // fill every item memory, then single symbols come back unrotated
        for (int c = 0; c < hdc_pkg::num_cores; c++) begin
            for (int a = 0; a < hdc_pkg::item_depth; a++) begin
                load_item(c, a, $urandom());
            end
        end
        for (int i = 0; i < n_item_checks; i++) begin
            s = $urandom_range(hdc_pkg::item_depth - 1, 0);
            do_init();
            do_sym(s);
            do_finish(1'b0, "item");
            for (int k = 0; k < got.size(); k++) begin
                check_value(model_item[k][s], got[k], $sformatf("item %0d core %0d", s, k));
            end
        end

        // back to back sequences
        // the first one wraps the position twice
        for (int i = 0; i < n_rand_seq; i++) begin
            n = (i == 0) ? max_syms : $urandom_range(max_syms, 1);
            fill_stim(n);
            do_init();
            send_stim(0);
            do_finish(1'b0, $sformatf("rand %0d", i));
        end

        // init mid sequence drops the prefix
        for (int i = 0; i < n_restart; i++) begin
            fill_stim($urandom_range(20, 1));
            do_init();
            send_stim(0);
            fill_stim($urandom_range(max_syms - 20, 1));
            do_init();
            send_stim(1);
            do_finish(1'b0, $sformatf("restart %0d", i));
        end

        // junk while busy, then continue without init
        // a leaked init or symbol would change the second result
        for (int i = 0; i < n_busy; i++) begin
            fill_stim($urandom_range(max_syms / 2, 1));
            do_init();
            send_stim(0);
            do_finish(1'b1, $sformatf("busy %0d a", i));
            fill_stim($urandom_range(max_syms / 2, 1));
            send_stim(0);
            do_finish(1'b0, $sformatf("busy %0d b", i));
        end

        // same list flat and gapped
        for (int i = 0; i < n_gap_seq; i++) begin
            fill_stim($urandom_range(max_syms, 1));
            do_init();
            send_stim(0);
            do_finish(1'b0, $sformatf("flat %0d", i));
            do_init();
            send_stim(max_gap);
            do_finish(1'b0, $sformatf("gapped %0d", i));
        end

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // bound from the load count and the worst case of every sequence
    initial begin
        #(watchdog_cycles * clk_period);
        $display("ERROR: simulation timed out after %0d cycles", watchdog_cycles);
        $display("summary: %0d checks, %0d errors", checks, errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+sim
design/hdc_pkg.sv
design/hdc_core.sv
design/hdc_core_array.sv
design/hdc_sequencer.sv
design/hdc_encoder_top.sv
sim/hdc_tb.sv

/* run.sh */
#!/bin/sh
# build the encoder testbench with verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module hdc_tb -f tb.f -o hdc_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/hdc_tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' "$log"; then
    exit 1
fi
exit 0
